//--- Bender.yml
package:
  name: adc_config

sources:
  - common/adc_cfg_pkg.sv
  - rtl/adc_auto_config.sv
  - rtl/adc_host_request.sv
  - rtl/adc_cfg_arbiter.sv
  - adc_spi/adc_spi_serializer.sv
  - rtl/adc_config_top.sv
  - target: test
    files:
      - testbench/adc_config_sva.sv
      - testbench/tb_adc_config.sv

//--- adc_spi/adc_spi_serializer.sv
////////////////////////////////////////////////////////////////////////////
// three-wire control port driver, shifts a 24 bit frame out MSB first
// serial clock is the divider MSB, all state steps happen on divider wrap
////////////////////////////////////////////////////////////////////////////
module adc_spi_serializer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start_i,  // one cycle, only honoured in idle
  input  adc_cfg_pkg::cfg_cmd_t cmd_i,
  output logic                  busy_o,
  output logic                  ctrl_clk_o,
  output logic                  ctrl_data_o,
  output logic                  ctrl_spi_rst_o,  // active low
  output logic                  mode_o           // low while data shifts
);
  import adc_cfg_pkg::*;

  logic [DIV_W-1:0]      div_q;      // free running clock divider
  logic                  wrap;
  logic [FRAME_BITS-1:0] shift_q;
  logic [BIT_W-1:0]      bit_cnt_q;  // data bits sent so far
  spi_state_e            state_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;  // rolls over by itself
    end
  end

  // all ones is the last cycle of a serial period, falling edge of ctrl_clk
  assign wrap = &div_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= SPI_IDLE;
      shift_q   <= '0;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        SPI_IDLE: begin
          if (start_i) begin
            shift_q   <= cmd_i;  // addr lands in the top byte
            bit_cnt_q <= '0;
            state_q   <= SPI_WAIT;
          end
        end
        SPI_WAIT: begin
          if (wrap) state_q <= SPI_STRB0;  // align to the divider
        end
        SPI_STRB0: begin
          if (wrap) state_q <= SPI_DATA;
        end
        SPI_DATA: begin
          if (wrap) begin
            // shift on the falling serial edge, stable at the next rise
            shift_q   <= {shift_q[FRAME_BITS-2:0], 1'b0};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == BIT_W'(FRAME_BITS - 1)) begin
              state_q <= SPI_COMMIT;
            end
          end
        end
        SPI_COMMIT: begin
          if (wrap) state_q <= SPI_STRB1;
        end
        SPI_STRB1: begin
          if (wrap) state_q <= SPI_SWAIT;
        end
        SPI_SWAIT: begin
          if (wrap) state_q <= SPI_IDLE;  // frame complete
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  assign busy_o = (state_q != SPI_IDLE);

  // no serial clock until the frame is aligned
  assign ctrl_clk_o = (state_q == SPI_IDLE || state_q == SPI_WAIT) ? 1'b0
                                                                   : div_q[DIV_W-1];

  assign ctrl_data_o    = shift_q[FRAME_BITS-1];
  assign ctrl_spi_rst_o = (state_q != SPI_WAIT);
  assign mode_o         = (state_q != SPI_DATA);  // enable only for data bits

endmodule

//--- common/adc_cfg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types, timing constants and mode lookup for the ADC config logic
// imported by every block of the serial control port path
////////////////////////////////////////////////////////////////////////////
package adc_cfg_pkg;

  // one serial frame, addr goes out first
  typedef struct packed {
    logic [7:0]  addr;
    logic [15:0] data;
  } cfg_cmd_t;

  typedef enum logic [2:0] {
    SPI_IDLE,    // nothing being sent
    SPI_WAIT,    // spi reset strobe low, waiting for divider wrap
    SPI_STRB0,   // one serial period before data
    SPI_DATA,    // 24 serial periods of data, mode line low
    SPI_COMMIT,  // commit period
    SPI_STRB1,
    SPI_SWAIT    // last guard period before idle
  } spi_state_e;

  typedef enum logic [2:0] {
    CONF_SETTLE,
    CONF_MODE_SET,
    CONF_LOAD,
    CONF_WAIT,
    CONF_RESET,
    CONF_DONE
  } conf_state_e;

  typedef enum logic [2:0] {
    MODE_ACHAN_DMUX1,  // one channel A, dmux 1:1
    MODE_ACHAN_DMUX2,
    MODE_CCHAN_DMUX1,  // one channel C
    MODE_CCHAN_DMUX2,
    MODE_2CHAN_DMUX1,  // both channels
    MODE_2CHAN_DMUX2,
    MODE_TEST_RAMP     // ramp test pattern
  } adc_mode_e;

  localparam logic [7:0] DEFAULT_ADDR  = 8'h81;
  localparam int         FRAME_BITS    = 24;
  localparam int         BIT_W         = $clog2(FRAME_BITS);  // bit counter width
  localparam int         DIV_W         = 3;                   // serial clk = clk / 8
  localparam int         SETTLE_CYCLES = 64;
  localparam int         SETTLE_W      = $clog2(SETTLE_CYCLES);

  // default config word for each operating mode
  function automatic logic [15:0] mode_word(adc_mode_e mode);
    case (mode)
      MODE_ACHAN_DMUX1: return 16'h0348;
      MODE_ACHAN_DMUX2: return 16'h0308;
      MODE_CCHAN_DMUX1: return 16'h034A;
      MODE_CCHAN_DMUX2: return 16'h030A;
      MODE_2CHAN_DMUX1: return 16'h0344;
      MODE_2CHAN_DMUX2: return 16'h0304;
      MODE_TEST_RAMP:   return 16'h1344;
      default:          return 16'h0348;  // unused code falls back to A chan
    endcase
  endfunction

endpackage

//--- rtl/adc_auto_config.sv
////////////////////////////////////////////////////////////////////////////
// power-up sequencer, sends the default frame once and pulses DDR reset
// holds the clock manager in reset until the sequence completes
////////////////////////////////////////////////////////////////////////////
module adc_auto_config (
  input  logic                   clk,
  input  logic                   rst,
  input  adc_cfg_pkg::adc_mode_e cfg_mode_i,
  input  logic                   grant_i,       // one cycle, from arbiter
  input  logic                   busy_i,        // serializer busy
  input  logic                   start_seen_i,  // start issued last cycle
  output logic                   req_o,
  output adc_cfg_pkg::cfg_cmd_t  cmd_o,
  output logic                   done_o,
  output logic                   ddrb_o,
  output logic                   dcm_reset_o
);
  import adc_cfg_pkg::*;

  conf_state_e         state_q;
  logic [SETTLE_W-1:0] settle_q;  // counts down the mode line settle time
  logic                ddrb_q;
  cfg_cmd_t            cmd_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= CONF_SETTLE;
      settle_q <= SETTLE_W'(SETTLE_CYCLES - 1);
      ddrb_q   <= 1'b0;
    end else begin
      ddrb_q <= 1'b0;  // single cycle pulse
      case (state_q)
        CONF_SETTLE: begin
          if (settle_q == '0) begin
            state_q <= CONF_MODE_SET;
          end else begin
            settle_q <= settle_q - 1'b1;
          end
        end
        CONF_MODE_SET: state_q <= CONF_LOAD;  // cmd_q latched here
        CONF_LOAD: begin
          if (grant_i) state_q <= CONF_WAIT;
        end
        CONF_WAIT: begin
          // busy only rises a cycle after the start, so skip that cycle
          if (!busy_i && !start_seen_i) begin
            state_q <= CONF_RESET;
            ddrb_q  <= 1'b1;  // high for the CONF_RESET cycle
          end
        end
        CONF_RESET: state_q <= CONF_DONE;
        CONF_DONE:  state_q <= CONF_DONE;  // parked until next reset
        default:    state_q <= CONF_SETTLE;
      endcase
    end
  end

  // default frame, mode pins are stable by now
  always_ff @(posedge clk) begin
    if (state_q == CONF_MODE_SET) begin
      cmd_q.addr <= DEFAULT_ADDR;
      cmd_q.data <= mode_word(cfg_mode_i);
    end
  end

  assign req_o       = (state_q == CONF_LOAD);
  assign cmd_o       = cmd_q;
  assign done_o      = (state_q == CONF_DONE);
  assign ddrb_o      = ddrb_q;
  assign dcm_reset_o = (state_q != CONF_DONE);  // released once configured

endmodule

//--- rtl/adc_cfg_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// picks auto or host command and issues one start pulse to the serializer
// auto request has priority, host writes wait for auto config to finish
////////////////////////////////////////////////////////////////////////////
module adc_cfg_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  auto_req_i,
  input  adc_cfg_pkg::cfg_cmd_t auto_cmd_i,
  input  logic                  auto_done_i,
  input  logic                  host_pending_i,
  input  adc_cfg_pkg::cfg_cmd_t host_cmd_i,
  input  logic                  busy_i,
  output logic                  auto_grant_o,
  output logic                  host_grant_o,
  output logic                  spi_start_o,
  output adc_cfg_pkg::cfg_cmd_t spi_cmd_o,
  output logic                  start_seen_o
);
  import adc_cfg_pkg::*;

  logic     start_q;  // also guards the cycle before busy rises
  logic     can_start;
  cfg_cmd_t cmd_q;

  assign can_start    = !busy_i && !start_q;
  assign auto_grant_o = can_start && auto_req_i;
  assign host_grant_o = can_start && !auto_req_i && auto_done_i && host_pending_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      start_q <= 1'b0;
    end else begin
      start_q <= auto_grant_o || host_grant_o;
    end
  end

  // command follows the grant, valid with spi_start_o
  always_ff @(posedge clk) begin
    if (auto_grant_o) begin
      cmd_q <= auto_cmd_i;
    end else if (host_grant_o) begin
      cmd_q <= host_cmd_i;
    end
  end

  assign spi_start_o  = start_q;
  assign spi_cmd_o    = cmd_q;
  assign start_seen_o = start_q;

endmodule

//--- rtl/adc_config_top.sv
////////////////////////////////////////////////////////////////////////////
// ADC control port top, power-up config and host writes share one serializer
////////////////////////////////////////////////////////////////////////////
module adc_config_top (
  input  logic                   clk,
  input  logic                   rst,
  input  adc_cfg_pkg::adc_mode_e cfg_mode_i,
  input  logic                   host_start_i,
  input  logic [7:0]             host_addr_i,
  input  logic [15:0]            host_data_i,
  output logic                   config_busy_o,
  output logic                   ddrb_o,
  output logic                   dcm_reset_o,
  output logic                   mode_o,
  output logic                   ctrl_clk_o,
  output logic                   ctrl_spi_rst_o,
  output logic                   ctrl_data_o
);
  import adc_cfg_pkg::*;

  logic     auto_req, auto_grant, auto_done;
  cfg_cmd_t auto_cmd;
  logic     host_pending, host_grant;
  cfg_cmd_t host_cmd;
  logic     spi_start, start_seen;
  cfg_cmd_t spi_cmd;
  logic     busy;

  adc_auto_config i_auto (
    .clk, .rst, .cfg_mode_i,
    .grant_i(auto_grant), .busy_i(busy), .start_seen_i(start_seen),
    .req_o(auto_req), .cmd_o(auto_cmd), .done_o(auto_done),
    .ddrb_o, .dcm_reset_o
  );

  adc_host_request i_host (
    .clk, .rst, .host_start_i, .host_addr_i, .host_data_i,
    .grant_i(host_grant), .pending_o(host_pending), .cmd_o(host_cmd)
  );

  adc_cfg_arbiter i_arb (
    .clk, .rst,
    .auto_req_i(auto_req), .auto_cmd_i(auto_cmd), .auto_done_i(auto_done),
    .host_pending_i(host_pending), .host_cmd_i(host_cmd), .busy_i(busy),
    .auto_grant_o(auto_grant), .host_grant_o(host_grant),
    .spi_start_o(spi_start), .spi_cmd_o(spi_cmd), .start_seen_o(start_seen)
  );

  adc_spi_serializer i_spi (
    .clk, .rst, .start_i(spi_start), .cmd_i(spi_cmd),
    .busy_o(busy), .ctrl_clk_o, .ctrl_data_o, .ctrl_spi_rst_o, .mode_o
  );

  assign config_busy_o = busy;  // frame in flight on the pins

endmodule

//--- rtl/adc_host_request.sv
////////////////////////////////////////////////////////////////////////////
// single slot for host register writes, held pending until granted
////////////////////////////////////////////////////////////////////////////
module adc_host_request (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  host_start_i,  // write strobe
  input  logic [7:0]            host_addr_i,
  input  logic [15:0]           host_data_i,
  input  logic                  grant_i,
  output logic                  pending_o,
  output adc_cfg_pkg::cfg_cmd_t cmd_o
);
  import adc_cfg_pkg::*;

  logic     pending_q;
  cfg_cmd_t slot_q;

  // a newer strobe simply replaces an unsent command
  always_ff @(posedge clk) begin
    if (host_start_i) begin
      slot_q.addr <= host_addr_i;
      slot_q.data <= host_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b0;
    end else if (host_start_i) begin
      pending_q <= 1'b1;  // strobe wins over a same cycle grant
    end else if (grant_i) begin
      pending_q <= 1'b0;
    end
  end

  assign pending_o = pending_q;
  assign cmd_o     = slot_q;

endmodule

//--- testbench/adc_config_sva.sv
////////////////////////////////////////////////////////////////////////////
// pin protocol assertions, bound into the control port top level
////////////////////////////////////////////////////////////////////////////
module adc_config_sva (
  input logic clk,
  input logic rst,
  input logic config_busy_i,
  input logic ctrl_clk_i,
  input logic ctrl_spi_rst_i,
  input logic mode_i,
  input logic ddrb_i
);

  int unsigned fail_cnt = 0;  // failed assertions so far

  // no serial clock outside a frame
  clk_idle_low: assert property (@(posedge clk) disable iff (rst)
    !config_busy_i |-> !ctrl_clk_i)
    else begin
      $error("ctrl clk toggling while not busy");
      fail_cnt++;
    end

  // reset strobe and data enable never overlap
  rst_mode_excl: assert property (@(posedge clk) disable iff (rst)
    !(!ctrl_spi_rst_i && !mode_i))
    else begin
      $error("spi reset and mode low together");
      fail_cnt++;
    end

  ddrb_single: assert property (@(posedge clk) disable iff (rst)
    ddrb_i |=> !ddrb_i)
    else begin
      $error("ddrb high for more than one cycle");
      fail_cnt++;
    end

endmodule

bind adc_config_top adc_config_sva i_sva (
  .clk, .rst,
  .config_busy_i(config_busy_o), .ctrl_clk_i(ctrl_clk_o),
  .ctrl_spi_rst_i(ctrl_spi_rst_o), .mode_i(mode_o), .ddrb_i(ddrb_o)
);

//--- testbench/tb_adc_config.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the ADC control port, decodes serial frames off the pins
// and compares them with frames built from the address and data driven
////////////////////////////////////////////////////////////////////////////
module tb_adc_config;
  import adc_cfg_pkg::*;

  localparam int        N_FRAMES       = 15;  // auto + 14 host writes
  localparam int        FRAME_CYCLES   = (FRAME_BITS + 5) * (1 << DIV_W) + 1;  // worst case
  localparam int        TIMEOUT_CYCLES = 10 + SETTLE_CYCLES + N_FRAMES * FRAME_CYCLES + 1000;
  localparam adc_mode_e TB_MODE        = MODE_2CHAN_DMUX2;

  logic        clk;
  logic        rst;
  adc_mode_e   cfg_mode_i;
  logic        host_start_i;
  logic [7:0]  host_addr_i;
  logic [15:0] host_data_i;
  logic        config_busy_o, ddrb_o, dcm_reset_o, mode_o;
  logic        ctrl_clk_o, ctrl_spi_rst_o, ctrl_data_o;

  logic [FRAME_BITS-1:0] got_q[$];   // decoded off the pins
  logic [FRAME_BITS-1:0] exp_q[$];   // what the tests asked for
  string                 name_q[$];  // test name per expected frame
  logic [FRAME_BITS-1:0] shift_r     = '0;
  logic [15:0]           lfsr        = 16'd91;
  int                    rises       = 0;
  int                    srst_pulses = 0;
  int                    frames_seen = 0;
  int                    ddrb_cnt    = 0;
  logic prev_clk  = 1'b0;
  logic prev_mode = 1'b1;
  logic prev_srst = 1'b1;
  logic prev_dcm  = 1'b1;

  adc_config_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // expected frame, address goes out ahead of data
  function automatic logic [FRAME_BITS-1:0] exp_frame(logic [7:0] addr, logic [15:0] data);
    return {addr, data};
  endfunction

  // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [FRAME_BITS-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      v    = {v[FRAME_BITS-2:0], lfsr[0]};
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED %s: expected 0x%0h actual 0x%0h", name, exp, act));
    end
  endtask

  task automatic expect_frame(input string name, input logic [7:0] addr,
                              input logic [15:0] data);
    exp_q.push_back(exp_frame(addr, data));
    name_q.push_back(name);
  endtask

  // one cycle write strobe, driven just after the edge
  task automatic send_host(input logic [7:0] addr, input logic [15:0] data);
    @(posedge clk);
    #1;
    host_start_i = 1'b1;
    host_addr_i  = addr;
    host_data_i  = data;
    @(posedge clk);
    #1;
    host_start_i = 1'b0;
  endtask

  // all expected frames seen and the serializer back in idle
  task automatic wait_idle();
    do begin
      @(posedge clk);
      #1;
    end while (exp_q.size() != 0 || config_busy_o);
  endtask

  // pin monitor, sampled on clk so the values are settled
  always @(posedge clk) begin
    if (!rst) begin
      if (ctrl_clk_o && !prev_clk && !mode_o) begin  // serial rise inside data phase
        shift_r = {shift_r[FRAME_BITS-2:0], ctrl_data_o};
        rises++;
      end
      if (!ctrl_spi_rst_o && prev_srst) srst_pulses++;
      if (mode_o && !prev_mode) begin  // data phase just ended
        frames_seen++;
        check_val("serial clock rises per frame", FRAME_BITS, rises);
        check_val("spi reset pulses before frame", frames_seen, srst_pulses);
        got_q.push_back(shift_r);
        rises = 0;
      end
      if (ddrb_o) ddrb_cnt++;
      if (prev_dcm && !dcm_reset_o) begin  // clock manager released
        check_val("busy low at dcm release", 0, config_busy_o);
        check_val("ddrb pulses before dcm release", 1, ddrb_cnt);
      end
    end
    prev_clk  = ctrl_clk_o;
    prev_mode = mode_o;
    prev_srst = ctrl_spi_rst_o;
    prev_dcm  = dcm_reset_o;
  end

  // protocol errors flagged by the bound checker
  always @(posedge clk) begin
    if (i_dut.i_sva.fail_cnt != 0) begin
      abort_run("a pin protocol assertion in the bound checker failed");
    end
  end

  // compares each decoded frame with the oldest expected one
  always @(posedge clk) begin
    logic [FRAME_BITS-1:0] got;
    string                 name;
    if (got_q.size() != 0) begin
      got = got_q.pop_front();
      if (exp_q.size() == 0) begin
        abort_run("a frame appeared on the serial pins that no test asked for");
      end else begin
        name = name_q.pop_front();
        check_val(name, exp_q.pop_front(), got);
      end
    end
  end

  initial begin
    int cycle_cnt;
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        abort_run($sformatf("timeout, run still going after %0d clock cycles", cycle_cnt));
      end
    end
  end

  initial begin
    logic [FRAME_BITS-1:0] rnd;
    rst          = 1'b1;
    cfg_mode_i   = TB_MODE;
    host_start_i = 1'b0;
    host_addr_i  = '0;
    host_data_i  = '0;
    repeat (10) @(posedge clk);
    // pins must be inactive while in reset
    check_val("reset busy", 0, config_busy_o);
    check_val("reset ddrb", 0, ddrb_o);
    check_val("reset ctrl clk", 0, ctrl_clk_o);
    check_val("reset spi rst", 1, ctrl_spi_rst_o);
    check_val("reset mode", 1, mode_o);
    check_val("reset dcm", 1, dcm_reset_o);
    #1 rst = 1'b0;

    expect_frame("auto default frame", DEFAULT_ADDR, mode_word(cfg_mode_i));
    repeat (20) @(posedge clk);  // still settling
    expect_frame("host write during auto config", 8'h3C, 16'hA55A);
    send_host(8'h3C, 16'hA55A);
    wait_idle();
    check_val("dcm released after config", 0, dcm_reset_o);

    expect_frame("single host write", 8'h12, 16'hBEEF);
    send_host(8'h12, 16'hBEEF);
    wait_idle();

    // second strobe while busy gets replaced by the third
    expect_frame("overwrite first", 8'h20, 16'h1111);
    send_host(8'h20, 16'h1111);
    do begin
      @(posedge clk);
      #1;
    end while (!config_busy_o);
    send_host(8'h21, 16'h2222);
    expect_frame("overwrite last", 8'h22, 16'h3333);
    send_host(8'h22, 16'h3333);
    wait_idle();

    for (int i = 0; i < 10; i++) begin
      rand_bits(FRAME_BITS, rnd);
      expect_frame($sformatf("random write %0d", i), rnd[23:16], rnd[15:0]);
      send_host(rnd[23:16], rnd[15:0]);
      wait_idle();
    end

    check_val("ddrb pulses total", 1, ddrb_cnt);
    check_val("frames decoded", N_FRAMES, frames_seen);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- vlog.f
common/adc_cfg_pkg.sv
rtl/adc_auto_config.sv
rtl/adc_host_request.sv
rtl/adc_cfg_arbiter.sv
adc_spi/adc_spi_serializer.sv
rtl/adc_config_top.sv
testbench/adc_config_sva.sv
testbench/tb_adc_config.sv
